/* flist.f */
hdl/status_bus_pkg.sv
hdl/status_req_reg.sv
hdl/status_region_decode.sv
hdl/status_read_combine.sv
hdl/status_bus_fabric.sv
tb/status_bus_assertions.sv
tb/tb_status_bus_fabric.sv

/* Makefile */
# Verilator build and run of the status bus fabric testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert \
		-f flist.f \
		--top-module tb_status_bus_fabric \
		-o Vtb_status_bus_fabric

run: compile
	./obj_dir/Vtb_status_bus_fabric > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_status_bus_fabric.sv */
// testbench for the status bus fabric
// host driver, client models, lfsr and per-test report
module tb_status_bus_fabric;
    timeunit 1ns;
    timeprecision 1ps;
    import status_bus_pkg::*;

    localparam logic [31:0] ETH_KEY    = 32'h5a5a0000;
    localparam logic [31:0] XCVR_KEY   = 32'h3c000000;
    localparam logic [31:0] CUSTOM_KEY = 32'h0f0f00f0;
    localparam int          WAIT_LIMIT = 100;

    logic          i_reconfig_clk;
    logic          arst;
    logic [31:0]   i_host_addr;
    logic          i_host_read;
    logic          i_host_write;
    logic [31:0]   i_host_writedata;
    logic [31:0]   o_host_readdata;
    logic          o_host_readdata_valid;
    logic          o_host_waitrequest;
    logic [15:0]   o_eth_addr;
    logic          o_eth_read;
    logic          o_eth_write;
    logic [31:0]   o_eth_writedata;
    logic          i_eth_waitrequest;
    logic [31:0]   i_eth_readdata;
    logic          i_eth_readdata_valid;
    logic [43:0]   o_xcvr_addr;
    logic [3:0]    o_xcvr_read;
    logic [3:0]    o_xcvr_write;
    logic [127:0]  o_xcvr_writedata;
    logic [3:0]    i_xcvr_waitrequest;
    logic [127:0]  i_xcvr_readdata;
    logic [29:0]   o_custom_addr;
    logic          o_custom_read;
    logic          o_custom_write;
    logic [31:0]   o_custom_writedata;
    logic [31:0]   i_custom_readdata;
    logic          i_custom_readdata_valid;

    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          eth_wait;
    int          custom_wait;
    int          xcvr_stall;
    logic [15:0] eth_word;
    logic [29:0] custom_word;
    logic        run_done;

    status_bus_fabric i_dut (.*);

    initial begin
        i_reconfig_clk = 1'b0;
        forever #4 i_reconfig_clk = ~i_reconfig_clk;
    end

    // galois lfsr, one step per bit
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // client models
    ////////////////////////////////////////////////////////////
    always @(posedge i_reconfig_clk) begin
        #2;
        i_eth_readdata_valid    = 1'b0;
        i_custom_readdata_valid = 1'b0;
        if (eth_wait > 0) begin
            eth_wait--;
            if (eth_wait == 0) begin
                i_eth_readdata_valid = 1'b1;
                i_eth_readdata       = {16'h0, eth_word} ^ ETH_KEY;
            end
        end
        if (o_eth_read) begin
            eth_wait = take_bits(3) + 1;
            eth_word = o_eth_addr;
        end
        if (custom_wait > 0) begin
            custom_wait--;
            if (custom_wait == 0) begin
                i_custom_readdata_valid = 1'b1;
                i_custom_readdata       = {2'b0, custom_word} ^ CUSTOM_KEY;
            end
        end
        if (o_custom_read) begin
            custom_wait = take_bits(3) + 1;
            custom_word = o_custom_addr;
        end
        // lane stalls for xcvr_stall cycles of a visible strobe
        i_xcvr_waitrequest = '0;
        for (int k = 0; k < NUM_XCVR; k++) begin
            if (o_xcvr_read[k] || o_xcvr_write[k]) begin
                i_xcvr_readdata[k*32 +: 32] = {21'h0, o_xcvr_addr[k*11 +: 11]} ^ (XCVR_KEY + 32'(k));
                if (xcvr_stall > 0) begin
                    i_xcvr_waitrequest[k] = 1'b1;
                    xcvr_stall--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // host driver
    ////////////////////////////////////////////////////////////
    task automatic host_access(input logic [31:0] addr, input logic rd, input logic wr,
                               input logic [31:0] data);
        int  t;
        logic taken;
        taken            = 1'b0;
        i_host_addr      = addr;
        i_host_read      = rd;
        i_host_write     = wr;
        i_host_writedata = data;
        for (t = 0; t < WAIT_LIMIT && !taken; t++) begin
            #4;
            taken = !o_host_waitrequest;
            @(posedge i_reconfig_clk);
            #1;
        end
        if (!taken) begin
            $display("host request at %h never accepted", addr);
            errors++;
        end
        i_host_read  = 1'b0;
        i_host_write = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        int   t;
        logic seen;
        seen = 1'b0;
        data = 'x;
        host_access(addr, 1'b1, 1'b0, 32'h0);
        for (t = 0; t < WAIT_LIMIT && !seen; t++) begin
            #4;
            if (o_host_readdata_valid) begin
                seen = 1'b1;
                data = o_host_readdata;
            end
            @(posedge i_reconfig_clk);
            #1;
        end
        if (!seen) begin
            $display("no read response for address %h", addr);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge i_reconfig_clk);
        #1;
    endtask

    task automatic report(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rdata;
        logic [10:0] off;
        logic [11:0] ew;
        int          e0;
        lfsr = 32'hb751;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        eth_wait = 0;
        custom_wait = 0;
        xcvr_stall = 0;
        run_done = 1'b0;
        arst = 1'b1;
        i_host_addr = '0;
        i_host_read = 1'b0;
        i_host_write = 1'b0;
        i_host_writedata = '0;
        i_eth_waitrequest = 1'b0;
        i_eth_readdata = '0;
        i_eth_readdata_valid = 1'b0;
        i_xcvr_waitrequest = '0;
        i_xcvr_readdata = '0;
        i_custom_readdata = '0;
        i_custom_readdata_valid = 1'b0;
        repeat (8) @(posedge i_reconfig_clk);
        #1 arst = 1'b0;

        e0 = errors;
        check_word("o_host_waitrequest", {31'h0, o_host_waitrequest}, 32'h0);
        check_word("o_xcvr_write", {28'h0, o_xcvr_write}, 32'h0);
        report("reset", e0);

        e0 = errors;
        for (int k = 0; k < NUM_XCVR; k++) begin
            off = 11'(take_bits(11));
            host_access({10'h0, XCVR_BASE + 20'(k) * XCVR_SPAN + {9'h0, off}, 2'b00},
                        1'b0, 1'b1, 32'(take_bits(16)));
            idle(2);
        end
        // lane 2 holds its write strobe for three cycles
        xcvr_stall = 3;
        host_access({10'h0, XCVR_BASE + 20'(2) * XCVR_SPAN + 20'h002a5, 2'b00},
                    1'b0, 1'b1, 32'hc0de_0002);
        idle(6);
        report("lane writes", e0);

        e0 = errors;
        host_access(32'h0000_3abc, 1'b0, 1'b1, 32'h5eed_0001);
        idle(2);
        for (int n = 0; n < 4; n++) begin
            ew = 12'(take_bits(12));
            read_word({18'h0, ew, 2'b00}, rdata);
            check_word("o_host_readdata", rdata, {20'h0, ew} ^ ETH_KEY);
            idle(2);
        end
        report("eth access", e0);

        e0 = errors;
        host_access(32'h8000_1230, 1'b0, 1'b1, 32'h1234_5678);
        idle(2);
        read_word(32'h8000_4560, rdata);
        check_word("o_host_readdata", rdata, {2'b0, 30'h2000_1158} ^ CUSTOM_KEY);
        idle(2);
        report("custom", e0);

        e0 = errors;
        read_word(32'h0002_0000, rdata);
        check_word("o_host_readdata", rdata, DEAD_READ_DATA);
        idle(2);
        report("timeout", e0);

        e0 = errors;
        for (int k = 0; k < NUM_XCVR; k++) begin
            off = 11'(take_bits(11));
            xcvr_stall = take_bits(2);
            read_word({10'h0, XCVR_BASE + 20'(k) * XCVR_SPAN + {9'h0, off}, 2'b00}, rdata);
            check_word("o_host_readdata", rdata, {21'h0, off} ^ (XCVR_KEY + 32'(k)));
            idle(2);
        end
        report("lane stall reads", e0);

        run_done = 1'b1;
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run cut short by a failed assertion
    final begin
        if (!run_done) $display("Simulation failed");
    end

endmodule

/* tb/status_bus_assertions.sv */
// concurrent checks on the status bus fabric, bound into the top level
module status_bus_assertions (
    input logic        i_reconfig_clk,
    input logic        arst,
    input logic [31:0] i_host_addr,
    input logic        i_host_read,
    input logic        i_host_write,
    input logic [31:0] i_host_writedata,
    input logic        o_host_waitrequest,
    input logic [31:0] o_host_readdata,
    input logic        o_host_readdata_valid,
    input logic [15:0] o_eth_addr,
    input logic        o_eth_read,
    input logic        o_eth_write,
    input logic [31:0] o_eth_writedata,
    input logic        i_eth_readdata_valid,
    input logic [31:0] i_eth_readdata,
    input logic [43:0] o_xcvr_addr,
    input logic [3:0]  o_xcvr_read,
    input logic [3:0]  o_xcvr_write,
    input logic [127:0] o_xcvr_writedata,
    input logic [3:0]  i_xcvr_waitrequest,
    input logic [127:0] i_xcvr_readdata,
    input logic [29:0] o_custom_addr,
    input logic        o_custom_read,
    input logic        o_custom_write,
    input logic [31:0] o_custom_writedata,
    input logic        i_pending
);
    timeunit 1ns;
    timeprecision 1ps;
    import status_bus_pkg::*;

    logic [19:0] host_word;
    logic        host_accept;
    logic        host_region;   // not custom
    logic        rd_open;       // read accepted, answer not yet seen

    assign host_word   = i_host_addr[21:2];
    assign host_accept = (i_host_read || i_host_write) && !o_host_waitrequest;
    assign host_region = !i_host_addr[CUSTOM_BIT];

    always_ff @(posedge i_reconfig_clk) begin
        if (arst) begin
            rd_open <= 1'b0;
        end else if (i_host_read && !o_host_waitrequest) begin
            rd_open <= 1'b1;
        end else if (o_host_readdata_valid) begin
            rd_open <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // reset and host side
    ////////////////////////////////////////////////////////////
    a_reset_idle: assert property (@(posedge i_reconfig_clk) arst |=>
        !o_eth_read && !o_eth_write && o_xcvr_read == '0 && o_xcvr_write == '0 &&
        !o_custom_read && !o_custom_write && !o_host_readdata_valid && !o_host_waitrequest)
        else $error("client strobe or host handshake active after reset");

    a_read_waits: assert property (@(posedge i_reconfig_clk) disable iff (arst)
        (rd_open && !o_host_readdata_valid) |-> o_host_waitrequest)
        else $error("host waitrequest low with a read outstanding");

    a_eth_write: assert property (@(posedge i_reconfig_clk) disable iff (arst)
        (i_host_write && !o_host_waitrequest && host_region && host_word <= ETH_LAST) |=>
        (o_eth_write && o_eth_addr == $past(host_word[15:0]) &&
         o_eth_writedata == $past(i_host_writedata) && o_xcvr_write == '0))
        else $error("ethernet write strobe, address or data wrong");

    a_eth_return: assert property (@(posedge i_reconfig_clk) disable iff (arst)
        (i_eth_readdata_valid && i_pending) |=>
        (o_host_readdata_valid && o_host_readdata == $past(i_eth_readdata)))
        else $error("ethernet read data not returned one cycle after valid");

    a_custom_same_cycle: assert property (@(posedge i_reconfig_clk) disable iff (arst)
        (host_accept && !host_region) |->
        (o_custom_read == i_host_read && o_custom_write == i_host_write &&
         o_custom_addr == i_host_addr[31:2] && o_custom_writedata == i_host_writedata &&
         !o_eth_read && !o_eth_write && o_xcvr_read == '0 && o_xcvr_write == '0))
        else $error("custom strobes do not follow the host strobes");

    // gap between the ethernet and transceiver spaces
    a_dead_read: assert property (@(posedge i_reconfig_clk) disable iff (arst)
        (i_host_read && !o_host_waitrequest && host_region &&
         host_word > ETH_LAST && host_word < XCVR_BASE) |->
        ##READ_TIMEOUT_CYCLES (o_host_readdata_valid && o_host_readdata == DEAD_READ_DATA))
        else $error("unmapped read did not time out with the default value");

    ////////////////////////////////////////////////////////////
    // per lane
    ////////////////////////////////////////////////////////////
    for (genvar k = 0; k < NUM_XCVR; k++) begin : g_lane
        a_lane_write: assert property (@(posedge i_reconfig_clk) disable iff (arst)
            (i_host_write && !o_host_waitrequest && host_region &&
             host_word >= XCVR_BASE + k * XCVR_SPAN &&
             host_word < XCVR_BASE + (k + 1) * XCVR_SPAN) |=>
            (o_xcvr_write == (4'b1 << k) && o_xcvr_read == '0 && !o_eth_read &&
             !o_eth_write && o_xcvr_addr[k*11 +: 11] == $past(i_host_addr[12:2]) &&
             o_xcvr_writedata[k*32 +: 32] == $past(i_host_writedata)))
            else $error("lane write strobe, address or data wrong");

        a_lane_hold: assert property (@(posedge i_reconfig_clk) disable iff (arst)
            ((o_xcvr_read[k] || o_xcvr_write[k]) && i_xcvr_waitrequest[k]) |->
            o_host_waitrequest ##1
            ($stable(o_xcvr_read[k]) && $stable(o_xcvr_write[k]) &&
             $stable(o_xcvr_addr[k*11 +: 11])))
            else $error("lane request moved while stalled");

        a_lane_read: assert property (@(posedge i_reconfig_clk) disable iff (arst)
            (o_xcvr_read[k] && !i_xcvr_waitrequest[k] && i_pending) |=>
            (o_host_readdata_valid && o_host_readdata == $past(i_xcvr_readdata[k*32 +: 32])))
            else $error("lane read data not returned");
    end

endmodule

bind status_bus_fabric status_bus_assertions u_checks (
    .i_reconfig_clk        (i_reconfig_clk),
    .arst                  (arst),
    .i_host_addr           (i_host_addr),
    .i_host_read           (i_host_read),
    .i_host_write          (i_host_write),
    .i_host_writedata      (i_host_writedata),
    .o_host_waitrequest    (o_host_waitrequest),
    .o_host_readdata       (o_host_readdata),
    .o_host_readdata_valid (o_host_readdata_valid),
    .o_eth_addr            (o_eth_addr),
    .o_eth_read            (o_eth_read),
    .o_eth_write           (o_eth_write),
    .o_eth_writedata       (o_eth_writedata),
    .i_eth_readdata_valid  (i_eth_readdata_valid),
    .i_eth_readdata        (i_eth_readdata),
    .o_xcvr_addr           (o_xcvr_addr),
    .o_xcvr_read           (o_xcvr_read),
    .o_xcvr_write          (o_xcvr_write),
    .o_xcvr_writedata      (o_xcvr_writedata),
    .i_xcvr_waitrequest    (i_xcvr_waitrequest),
    .i_xcvr_readdata       (i_xcvr_readdata),
    .o_custom_addr         (o_custom_addr),
    .o_custom_read         (o_custom_read),
    .o_custom_write        (o_custom_write),
    .o_custom_writedata    (o_custom_writedata),
    .i_pending             (pending)
);

/* hdl/status_bus_fabric.sv */
// status bus fabric top level
// request register, region decoder and read combiner
module status_bus_fabric (
    input  logic                                     i_reconfig_clk,
    input  logic                                     arst,
    // host
    input  logic [status_bus_pkg::HOST_ADDR_W-1:0]   i_host_addr,
    input  logic                                     i_host_read,
    input  logic                                     i_host_write,
    input  logic [status_bus_pkg::DATA_W-1:0]        i_host_writedata,
    output logic [status_bus_pkg::DATA_W-1:0]        o_host_readdata,
    output logic                                     o_host_readdata_valid,
    output logic                                     o_host_waitrequest,
    // ethernet
    output logic [status_bus_pkg::ETH_ADDR_W-1:0]    o_eth_addr,
    output logic                                     o_eth_read,
    output logic                                     o_eth_write,
    output logic [status_bus_pkg::DATA_W-1:0]        o_eth_writedata,
    input  logic                                     i_eth_waitrequest,
    input  logic [status_bus_pkg::DATA_W-1:0]        i_eth_readdata,
    input  logic                                     i_eth_readdata_valid,
    // transceiver lanes
    output logic [status_bus_pkg::NUM_XCVR*status_bus_pkg::XCVR_ADDR_W-1:0] o_xcvr_addr,
    output logic [status_bus_pkg::NUM_XCVR-1:0]      o_xcvr_read,
    output logic [status_bus_pkg::NUM_XCVR-1:0]      o_xcvr_write,
    output logic [status_bus_pkg::NUM_XCVR*status_bus_pkg::DATA_W-1:0] o_xcvr_writedata,
    input  logic [status_bus_pkg::NUM_XCVR-1:0]      i_xcvr_waitrequest,
    input  logic [status_bus_pkg::NUM_XCVR*status_bus_pkg::DATA_W-1:0] i_xcvr_readdata,
    // custom client
    output logic [status_bus_pkg::CUSTOM_ADDR_W-1:0] o_custom_addr,
    output logic                                     o_custom_read,
    output logic                                     o_custom_write,
    output logic [status_bus_pkg::DATA_W-1:0]        o_custom_writedata,
    input  logic [status_bus_pkg::DATA_W-1:0]        i_custom_readdata,
    input  logic                                     i_custom_readdata_valid
);
    import status_bus_pkg::*;

    logic                   acc_read;
    logic                   acc_write;
    logic                   accept;
    logic                   sel_stall;
    logic                   pending;
    logic                   req_read;
    logic                   req_write;
    logic [HOST_ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0]      req_writedata;
    logic                   xcvr_rd_valid;
    logic [DATA_W-1:0]      xcvr_rd_data;

    assign o_host_waitrequest = pending | sel_stall;

    // strobes that are taken this cycle
    assign acc_read  = i_host_read & ~o_host_waitrequest;
    assign acc_write = i_host_write & ~o_host_waitrequest;
    assign accept    = acc_read | acc_write;

    status_req_reg u_req_reg (
        .i_reconfig_clk   (i_reconfig_clk),
        .arst             (arst),
        .i_host_read      (acc_read),
        .i_host_write     (acc_write),
        .i_host_addr      (i_host_addr),
        .i_host_writedata (i_host_writedata),
        .i_sel_stall      (sel_stall),
        .o_req_read       (req_read),
        .o_req_write      (req_write),
        .o_req_addr       (req_addr),
        .o_req_writedata  (req_writedata)
    );

    status_region_decode u_decode (
        .i_req_read         (req_read),
        .i_req_write        (req_write),
        .i_req_addr         (req_addr),
        .i_req_writedata    (req_writedata),
        .i_host_read        (acc_read),
        .i_host_write       (acc_write),
        .i_host_addr        (i_host_addr),
        .i_host_writedata   (i_host_writedata),
        .o_eth_addr         (o_eth_addr),
        .o_eth_read         (o_eth_read),
        .o_eth_write        (o_eth_write),
        .o_eth_writedata    (o_eth_writedata),
        .i_eth_waitrequest  (i_eth_waitrequest),
        .o_xcvr_addr        (o_xcvr_addr),
        .o_xcvr_read        (o_xcvr_read),
        .o_xcvr_write       (o_xcvr_write),
        .o_xcvr_writedata   (o_xcvr_writedata),
        .i_xcvr_waitrequest (i_xcvr_waitrequest),
        .i_xcvr_readdata    (i_xcvr_readdata),
        .o_custom_addr      (o_custom_addr),
        .o_custom_read      (o_custom_read),
        .o_custom_write     (o_custom_write),
        .o_custom_writedata (o_custom_writedata),
        .o_sel_stall        (sel_stall),
        .o_xcvr_rd_valid    (xcvr_rd_valid),
        .o_xcvr_rd_data     (xcvr_rd_data)
    );

    status_read_combine u_combine (
        .i_reconfig_clk          (i_reconfig_clk),
        .arst                    (arst),
        .i_host_read             (i_host_read),
        .i_accept                (accept),
        .i_eth_readdata_valid    (i_eth_readdata_valid),
        .i_eth_readdata          (i_eth_readdata),
        .i_xcvr_rd_valid         (xcvr_rd_valid),
        .i_xcvr_rd_data          (xcvr_rd_data),
        .i_custom_readdata_valid (i_custom_readdata_valid),
        .i_custom_readdata       (i_custom_readdata),
        .o_pending               (pending),
        .o_host_readdata         (o_host_readdata),
        .o_host_readdata_valid   (o_host_readdata_valid)
    );

endmodule

/* hdl/status_read_combine.sv */
// read response merge for eth, xcvr and custom clients
// outstanding read FSM with timeout default
module status_read_combine (
    input  logic                              i_reconfig_clk,
    input  logic                              arst,
    input  logic                              i_host_read,
    input  logic                              i_accept,
    input  logic                              i_eth_readdata_valid,
    input  logic [status_bus_pkg::DATA_W-1:0] i_eth_readdata,
    input  logic                              i_xcvr_rd_valid,
    input  logic [status_bus_pkg::DATA_W-1:0] i_xcvr_rd_data,
    input  logic                              i_custom_readdata_valid,
    input  logic [status_bus_pkg::DATA_W-1:0] i_custom_readdata,
    output logic                              o_pending,
    output logic [status_bus_pkg::DATA_W-1:0] o_host_readdata,
    output logic                              o_host_readdata_valid
);
    import status_bus_pkg::*;

    combine_state_e       state;
    combine_state_e       state_nxt;
    logic [TIMEOUT_W-1:0] timer;
    logic                 rd_start;
    logic                 any_valid;
    logic                 timed_out;
    logic                 done;
    logic [DATA_W-1:0]    resp_data;

    assign rd_start  = i_host_read & i_accept;
    assign any_valid = i_eth_readdata_valid | i_xcvr_rd_valid | i_custom_readdata_valid;
    assign timed_out = (timer == TIMEOUT_W'(READ_TIMEOUT_CYCLES - 1));
    assign done      = (state == CMB_WAIT) && (any_valid || timed_out);
    assign o_pending = (state == CMB_WAIT);

    // eth first, then xcvr, then custom
    always_comb begin
        if (i_eth_readdata_valid) begin
            resp_data = i_eth_readdata;
        end else if (i_xcvr_rd_valid) begin
            resp_data = i_xcvr_rd_data;
        end else if (i_custom_readdata_valid) begin
            resp_data = i_custom_readdata;
        end else begin
            resp_data = DEAD_READ_DATA;   // nobody answered
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            CMB_IDLE: if (rd_start) state_nxt = CMB_WAIT;
            CMB_WAIT: if (done) state_nxt = CMB_IDLE;
            default:  state_nxt = CMB_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state, timer, response
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_reconfig_clk) begin
        if (arst) begin
            state                 <= CMB_IDLE;
            timer                 <= '0;
            o_host_readdata_valid <= 1'b0;
        end else begin
            state                 <= state_nxt;
            o_host_readdata_valid <= done;   // single pulse per read
            if (rd_start) begin
                timer <= TIMEOUT_W'(1);
            end else if (state == CMB_WAIT) begin
                timer <= timer + 1'b1;
            end
        end
    end

    always_ff @(posedge i_reconfig_clk) begin
        if (done) begin
            o_host_readdata <= resp_data;
        end
    end

endmodule

/* hdl/status_region_decode.sv */
// region decode, client strobes and address slices, stall select
// transceiver read data mux and custom client path
module status_region_decode (
    input  logic                                     i_req_read,
    input  logic                                     i_req_write,
    input  logic [status_bus_pkg::HOST_ADDR_W-1:0]   i_req_addr,
    input  logic [status_bus_pkg::DATA_W-1:0]        i_req_writedata,
    input  logic                                     i_host_read,
    input  logic                                     i_host_write,
    input  logic [status_bus_pkg::HOST_ADDR_W-1:0]   i_host_addr,
    input  logic [status_bus_pkg::DATA_W-1:0]        i_host_writedata,
    // ethernet
    output logic [status_bus_pkg::ETH_ADDR_W-1:0]    o_eth_addr,
    output logic                                     o_eth_read,
    output logic                                     o_eth_write,
    output logic [status_bus_pkg::DATA_W-1:0]        o_eth_writedata,
    input  logic                                     i_eth_waitrequest,
    // transceiver lanes
    output logic [status_bus_pkg::NUM_XCVR*status_bus_pkg::XCVR_ADDR_W-1:0] o_xcvr_addr,
    output logic [status_bus_pkg::NUM_XCVR-1:0]      o_xcvr_read,
    output logic [status_bus_pkg::NUM_XCVR-1:0]      o_xcvr_write,
    output logic [status_bus_pkg::NUM_XCVR*status_bus_pkg::DATA_W-1:0] o_xcvr_writedata,
    input  logic [status_bus_pkg::NUM_XCVR-1:0]      i_xcvr_waitrequest,
    input  logic [status_bus_pkg::NUM_XCVR*status_bus_pkg::DATA_W-1:0] i_xcvr_readdata,
    // custom client
    output logic [status_bus_pkg::CUSTOM_ADDR_W-1:0] o_custom_addr,
    output logic                                     o_custom_read,
    output logic                                     o_custom_write,
    output logic [status_bus_pkg::DATA_W-1:0]        o_custom_writedata,
    // toward the combiner
    output logic                                     o_sel_stall,
    output logic                                     o_xcvr_rd_valid,
    output logic [status_bus_pkg::DATA_W-1:0]        o_xcvr_rd_data
);
    import status_bus_pkg::*;

    logic [STATUS_ADDR_W-1:0] req_word;
    logic                     req_custom;
    logic                     req_any;
    region_e                  region;
    logic [XCVR_SEL_W-1:0]    lane;
    logic                     eth_sel;
    logic [NUM_XCVR-1:0]      xcvr_sel;
    logic                     sel_wait;
    logic                     custom_any;

    assign req_word   = i_req_addr[STATUS_ADDR_W+1:2];
    assign req_custom = i_req_addr[CUSTOM_BIT];
    assign req_any    = i_req_read | i_req_write;

    ////////////////////////////////////////////////////////////
    // region map
    ////////////////////////////////////////////////////////////
    always_comb begin
        logic [STATUS_ADDR_W-1:0] lane_lo;
        region  = REGION_NONE;
        lane    = '0;
        lane_lo = XCVR_BASE;
        // eth space is aligned to its size
        if (!req_custom && ((req_word & ~ETH_LAST) == ETH_BASE)) begin
            region = REGION_ETH;
        end
        for (int k = 0; k < NUM_XCVR; k++) begin
            lane_lo = XCVR_BASE + STATUS_ADDR_W'(k) * XCVR_SPAN;
            if (!req_custom && req_word >= lane_lo && req_word < lane_lo + XCVR_SPAN) begin
                region = region_e'(int'(REGION_XCVR0) + k);
                lane   = XCVR_SEL_W'(k);
            end
        end
    end

    // one client select and its waitrequest
    always_comb begin
        eth_sel  = 1'b0;
        xcvr_sel = '0;
        sel_wait = 1'b0;
        case (region)
            REGION_ETH: begin
                eth_sel  = 1'b1;
                sel_wait = i_eth_waitrequest;
            end
            REGION_XCVR0, REGION_XCVR1, REGION_XCVR2, REGION_XCVR3: begin
                xcvr_sel[lane] = 1'b1;
                sel_wait       = i_xcvr_waitrequest[lane];
            end
            default: ;   // unmapped, request dropped
        endcase
    end

    assign o_sel_stall = req_any && sel_wait;

    ////////////////////////////////////////////////////////////
    // client strobes
    ////////////////////////////////////////////////////////////
    assign o_eth_read      = i_req_read & eth_sel;
    assign o_eth_write     = i_req_write & eth_sel;
    assign o_eth_addr      = (eth_sel && req_any) ? req_word[ETH_ADDR_W-1:0] : '0;
    assign o_eth_writedata = i_req_writedata;

    assign o_xcvr_read      = {NUM_XCVR{i_req_read}} & xcvr_sel;
    assign o_xcvr_write     = {NUM_XCVR{i_req_write}} & xcvr_sel;
    assign o_xcvr_writedata = {NUM_XCVR{i_req_writedata}};

    for (genvar k = 0; k < NUM_XCVR; k++) begin : g_lane_addr
        assign o_xcvr_addr[k*XCVR_ADDR_W +: XCVR_ADDR_W] =
            (xcvr_sel[k] && req_any) ? req_word[XCVR_ADDR_W-1:0] : '0;
    end

    // xcvr data is valid when the read is no longer stalled
    assign o_xcvr_rd_valid = |(o_xcvr_read & ~i_xcvr_waitrequest);
    assign o_xcvr_rd_data  = i_xcvr_readdata[lane*DATA_W +: DATA_W];

    // custom path bypasses the request register
    assign o_custom_read      = i_host_read & i_host_addr[CUSTOM_BIT];
    assign o_custom_write     = i_host_write & i_host_addr[CUSTOM_BIT];
    assign custom_any         = o_custom_read | o_custom_write;
    assign o_custom_addr      = custom_any ? i_host_addr[HOST_ADDR_W-1:2] : '0;
    assign o_custom_writedata = i_host_writedata;

endmodule

/* hdl/status_req_reg.sv */
// host request register, frozen while the selected client stalls
module status_req_reg (
    input  logic                                   i_reconfig_clk,
    input  logic                                   arst,
    input  logic                                   i_host_read,
    input  logic                                   i_host_write,
    input  logic [status_bus_pkg::HOST_ADDR_W-1:0] i_host_addr,
    input  logic [status_bus_pkg::DATA_W-1:0]      i_host_writedata,
    input  logic                                   i_sel_stall,
    output logic                                   o_req_read,
    output logic                                   o_req_write,
    output logic [status_bus_pkg::HOST_ADDR_W-1:0] o_req_addr,
    output logic [status_bus_pkg::DATA_W-1:0]      o_req_writedata
);

    logic capture;

    // a new strobe always loads, otherwise hold while stalled
    assign capture = !i_sel_stall || i_host_read || i_host_write;

    always_ff @(posedge i_reconfig_clk) begin
        if (arst) begin
            o_req_read  <= 1'b0;
            o_req_write <= 1'b0;
        end else if (capture) begin
            o_req_read  <= i_host_read;
            o_req_write <= i_host_write;
        end
    end

    // payload follows the strobes
    always_ff @(posedge i_reconfig_clk) begin
        if (capture) begin
            o_req_addr      <= i_host_addr;
            o_req_writedata <= i_host_writedata;
        end
    end

endmodule

/* hdl/status_bus_pkg.sv */
// status bus widths, region map, read timeout and default answer
// region and combiner state enums
package status_bus_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int HOST_ADDR_W   = 32;   // host byte address
    localparam int DATA_W        = 32;
    localparam int STATUS_ADDR_W = 20;   // word address, host bits 21:2
    localparam int CUSTOM_ADDR_W = 30;   // word address, host bits 31:2
    localparam int ETH_ADDR_W    = 16;
    localparam int XCVR_ADDR_W   = 11;
    localparam int NUM_XCVR      = 4;
    localparam int XCVR_SEL_W    = $clog2(NUM_XCVR);

    ////////////////////////////////////////////////////////////
    // word address map
    ////////////////////////////////////////////////////////////
    localparam logic [STATUS_ADDR_W-1:0] ETH_BASE  = 20'h00000;
    localparam logic [STATUS_ADDR_W-1:0] ETH_LAST  = 20'h00FFF;
    localparam logic [STATUS_ADDR_W-1:0] XCVR_BASE = 20'h10000;
    localparam logic [STATUS_ADDR_W-1:0] XCVR_SPAN = 20'h01000; // per lane

    localparam int CUSTOM_BIT = 31;   // host byte address bit

    // read return
    localparam int READ_TIMEOUT_CYCLES = 32;
    localparam int TIMEOUT_W           = $clog2(READ_TIMEOUT_CYCLES);
    localparam logic [DATA_W-1:0] DEAD_READ_DATA = 32'hDEADC0DE;

    typedef enum logic [2:0] {
        REGION_ETH,
        REGION_XCVR0,
        REGION_XCVR1,
        REGION_XCVR2,
        REGION_XCVR3,
        REGION_NONE
    } region_e;

    typedef enum logic {
        CMB_IDLE,
        CMB_WAIT
    } combine_state_e;

endpackage
